//--- testbench/vlsu_shuffle_testdata.txt
# Load shuffle test vectors, every field in hex
# kind req_id sew vd vstart vm cmt_cnt mask hold_lane hold_cycles
# kind 1 queues four requests (req_id and vd counting up) before any beat
# hold_lane f means every lane returns its credits right away
0 1 0 02 0000 1 00 0000000000000000 f 00
0 2 1 03 0010 1 00 0000000000000000 f 00
0 3 2 04 0000 1 00 0000000000000000 f 00
0 4 3 05 0020 1 00 0000000000000000 f 00
0 5 2 06 0000 0 01 f0f0a5a5ffff0001 f 00
0 6 0 07 0008 0 00 0123456789abcdef f 00
0 7 1 09 0004 1 03 0000000000000000 f 00
0 8 0 01 0000 1 05 0000000000000000 2 14
1 9 2 08 0000 1 01 0000000000000000 f 00

//--- files.f
+incdir+include
logic/vlsu_shuffle_pkg.sv
logic/shf_info_queue.sv
logic/shf_nibble_xbar.sv
logic/shf_shuffle_unit.sv
logic/vlsu_shuffle_top.sv
testbench/vlsu_shuffle_properties.sv
testbench/vlsu_shuffle_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = vlsu_shuffle_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test OK

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/vlsu_shuffle_tb.sv
`timescale 1ns/1ps
`include "vlsu_shuffle_defs.svh"

module vlsu_shuffle_tb;
  import vlsu_shuffle_pkg::*;

  localparam int DEPTH       = 4;
  localparam int MAX_TESTS   = 16;
  // Watchdog budget per test
  localparam int TEST_CYCLES = 200;

  logic                                    clk_i = 1'b0;
  logic                                    rst_ni;
  logic                                    meta_valid_i;
  logic                                    meta_ready_o;
  meta_cmd_t                               meta_i;
  logic                                    seq_valid_i;
  logic                                    seq_ready_o;
  logic [`SEQ_NIBS-1:0][3:0]               seq_data_i;
  logic [`SEQ_NIBS-1:0]                    seq_en_i;
  logic                                    mask_valid_i;
  logic [`NR_LANES-1:0][`NIB_PER_LANE-1:0] mask_bits_i;
  logic                                    mask_ready_o;
  logic [`NR_LANES-1:0]                    lane_valid_o;
  lane_word_t [`NR_LANES-1:0]              lane_word_o;
  logic [`NR_LANES-1:0]                    lane_credit_i;

  // Test table, one row per data line
  logic [63:0] tv [MAX_TESTS][10];
  int          n_tests = 0;
  bit          loaded  = 1'b0;

  // Reference words still owed to each lane
  lane_word_t  exp_q [`NR_LANES][$];
  // Beats seen and credits given back, per lane
  int          rcvd [`NR_LANES] = '{default: 0};
  int          ret  [`NR_LANES] = '{default: 0};
  bit          hold_on   = 1'b0;
  int          hold_lane = 0;
  int          errors    = 0;
  int          n_failed  = 0;
  logic [31:0] lcg_state = 32'd69;

  vlsu_shuffle_top #(
    .INFO_DEPTH (DEPTH)
  ) i_vlsu_shuffle_top (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .meta_valid_i  (meta_valid_i),
    .meta_ready_o  (meta_ready_o),
    .meta_i        (meta_i),
    .seq_valid_i   (seq_valid_i),
    .seq_ready_o   (seq_ready_o),
    .seq_data_i    (seq_data_i),
    .seq_en_i      (seq_en_i),
    .mask_valid_i  (mask_valid_i),
    .mask_bits_i   (mask_bits_i),
    .mask_ready_o  (mask_ready_o),
    .lane_valid_o  (lane_valid_o),
    .lane_word_o   (lane_word_o),
    .lane_credit_i (lane_credit_i)
  );

  bind shf_shuffle_unit vlsu_shuffle_properties i_vlsu_shuffle_properties (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lane_valid_i  (lane_valid_o),
    .lane_credit_i (lane_credit_i),
    .credit_i      (credit_q),
    .commit_i      (commit_o),
    .info_valid_i  (info_valid_i),
    .cmt_cnt_i     (info_i.cmt_cnt),
    .vaddr_set_i   (info_i.vaddr_set)
  );

  always #5 clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic compare_value(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors = errors + 1;
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // vd base set plus the sets skipped by vstart, bank in the low bits
  function automatic logic [9:0] start_addr(logic [4:0] vd, logic [15:0] vstart,
                                            logic [1:0] sew);
    int elem;
    elem = int'(vstart) / `NR_LANES;
    return 10'(int'(vd) * `SETS_PER_VREG + (elem >> (3 - int'(sew))));
  endfunction

  function automatic lane_word_t expect_word(int lane, logic [`SEQ_NIBS*4-1:0] data,
                                             logic [`SEQ_NIBS-1:0] en, logic [63:0] mask,
                                             logic [1:0] sew, logic vm, logic [3:0] id,
                                             logic [7:0] set, logic [1:0] bank);
    lane_word_t w;
    int s;
    int idx;
    // Element size in nibbles
    s = 2 << sew;
    for (int o = 0; o < `NIB_PER_LANE; o++) begin
      // Element o / s of this lane, nibble o % s inside it
      idx = ((o / s) * `NR_LANES + lane) * s + o % s;
      w.data[o*4 +: 4] = data[idx*4 +: 4];
      w.nbe[o]         = en[idx] & (vm | mask[lane*`NIB_PER_LANE + o]);
    end
    w.req_id     = id;
    w.vaddr_set  = set;
    w.vaddr_bank = bank;
    return w;
  endfunction

  function automatic bit lanes_idle();
    for (int l = 0; l < `NR_LANES; l++) begin
      if (exp_q[l].size() != 0 || rcvd[l] != ret[l]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic load_tests();
    int          fd;
    int          r;
    string       line;
    logic [63:0] f [10];
    fd = $fopen("testbench/vlsu_shuffle_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        r = $fgets(line, fd);
        // Skip blank and comment lines
        if (r > 1 && line.getc(0) != "#") begin
          r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
          if (r == 10) begin
            for (int i = 0; i < 10; i++) begin
              tv[n_tests][i] = f[i];
            end
            n_tests++;
          end
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
  endtask

  task automatic send_meta(input meta_cmd_t cmd);
    @(posedge clk_i);
    meta_valid_i <= 1'b1;
    meta_i       <= cmd;
    @(negedge clk_i);
    while (!meta_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    meta_valid_i <= 1'b0;
  endtask

  task automatic send_beat(input logic [`SEQ_NIBS*4-1:0] data, input logic [`SEQ_NIBS-1:0] en,
                           input logic [63:0] mask, input logic vm);
    @(posedge clk_i);
    seq_valid_i  <= 1'b1;
    seq_data_i   <= data;
    seq_en_i     <= en;
    mask_valid_i <= !vm;
    mask_bits_i  <= mask;
    @(negedge clk_i);
    while (!seq_ready_o) begin
      @(negedge clk_i);
    end
    // Mask word goes with a masked beat only
    compare_value(128'(mask_ready_o), 128'(!vm), "mask_ready_o at commit");
    @(posedge clk_i);
    seq_valid_i  <= 1'b0;
    mask_valid_i <= 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // One data line: requests, beats, optional credit hold
  // --------------------------------------------------------------------------
  task automatic run_test(input int t);
    meta_cmd_t               cmd;
    logic [9:0]              addr [DEPTH];
    logic [`SEQ_NIBS*4-1:0]  data;
    logic [`SEQ_NIBS-1:0]    en;
    int                      nreq;
    int                      nbeat;
    int                      hl;
    int                      base;
    int                      err0;
    err0  = errors;
    nreq  = (tv[t][0] != 0) ? DEPTH : 1;
    nbeat = int'(tv[t][6][7:0]) + 1;
    hl    = int'(tv[t][8][3:0]);
    for (int r = 0; r < nreq; r++) begin
      cmd.req_id  = 4'(tv[t][1] + 64'(r));
      cmd.sew     = tv[t][2][1:0];
      cmd.vd      = 5'(tv[t][3] + 64'(r));
      cmd.vstart  = tv[t][4][15:0];
      cmd.vm      = tv[t][5][0];
      cmd.cmt_cnt = tv[t][6][7:0];
      addr[r]     = start_addr(cmd.vd, cmd.vstart, cmd.sew);
      send_meta(cmd);
    end
    @(negedge clk_i);
    if (nreq == DEPTH) begin
      compare_value(128'(meta_ready_o), 128'(0), "meta_ready_o with a full queue");
    end
    base      = (hl < `NR_LANES) ? rcvd[hl] : 0;
    hold_lane = hl;
    hold_on   = (hl < `NR_LANES);
    fork
      begin
        for (int r = 0; r < nreq; r++) begin
          for (int b = 0; b < nbeat; b++) begin
            for (int i = 0; i < `SEQ_NIBS / 8; i++) begin
              data[i*32 +: 32] = lcg_next();
            end
            en[31:0]  = lcg_next();
            en[63:32] = lcg_next();
            for (int l = 0; l < `NR_LANES; l++) begin
              exp_q[l].push_back(expect_word(l, data, en, tv[t][7], tv[t][2][1:0],
                                             tv[t][5][0], 4'(tv[t][1] + 64'(r)),
                                             addr[r][9:2] + 8'(b), addr[r][1:0]));
            end
            send_beat(data, en, tv[t][7], tv[t][5][0]);
            // Head popped after its last beat frees a queue slot
            if (nreq == DEPTH && r == 0 && b == nbeat - 1) begin
              @(negedge clk_i);
              compare_value(128'(meta_ready_o), 128'(1), "meta_ready_o after a pop");
            end
          end
        end
      end
      begin
        if (hold_on) begin
          repeat (tv[t][9]) @(negedge clk_i);
          compare_value(128'(rcvd[hl] - base), 128'(`LANE_CREDITS), "beats on the held lane");
          compare_value(128'(seq_ready_o), 128'(0), "seq_ready_o while credits are held");
          hold_on = 1'b0;
        end
      end
    join
    @(negedge clk_i);
    while (!lanes_idle()) begin
      @(negedge clk_i);
    end
    if (errors != err0) begin
      n_failed++;
    end
    $display("test %0d: kind %0d sew %0d requests %0d beats %0d, %s", t, tv[t][0],
             tv[t][2], nreq, nbeat, (errors == err0) ? "passed" : "failed");
  endtask

  // --------------------------------------------------------------------------
  // Lane receivers
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin
    for (int l = 0; l < `NR_LANES; l++) begin
      if (rst_ni && lane_valid_o[l]) begin
        rcvd[l] = rcvd[l] + 1;
        if (exp_q[l].size() == 0) begin
          $display("unexpected beat on lane %0d at %0t ns, none was pending", l, $time);
          errors = errors + 1;
        end else begin
          compare_value(128'(lane_word_o[l]), 128'(exp_q[l].pop_front()),
                        $sformatf("lane %0d word", l));
        end
      end
    end
  end

  // One credit back per cycle, unless that lane is held
  always @(posedge clk_i) begin
    for (int l = 0; l < `NR_LANES; l++) begin
      if (rcvd[l] != ret[l] && !(hold_on && hold_lane == l)) begin
        lane_credit_i[l] <= 1'b1;
        ret[l]           <= ret[l] + 1;
      end else begin
        lane_credit_i[l] <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------------
  initial begin
    int asrt;
    rst_ni        = 1'b0;
    meta_valid_i  = 1'b0;
    meta_i        = '0;
    seq_valid_i   = 1'b0;
    seq_data_i    = '0;
    seq_en_i      = '0;
    mask_valid_i  = 1'b0;
    mask_bits_i   = '0;
    lane_credit_i = '0;
    load_tests();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    compare_value(128'(lane_valid_o), 128'(0), "lane_valid_o after reset");
    compare_value(128'(seq_ready_o), 128'(0), "seq_ready_o after reset");
    compare_value(128'(mask_ready_o), 128'(0), "mask_ready_o after reset");
    compare_value(128'(meta_ready_o), 128'(1), "meta_ready_o after reset");
    if (errors != 0) begin
      n_failed++;
    end
    $display("test reset: %s", (errors == 0) ? "passed" : "failed");
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    asrt = i_vlsu_shuffle_top.i_shf_shuffle_unit.i_vlsu_shuffle_properties.fail_cnt;
    if (n_tests == 0) begin
      $display("no test vectors were read");
    end
    $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
             n_tests + 1, n_failed, errors, asrt);
    if (errors == 0 && asrt == 0 && n_tests > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (TEST_CYCLES * (n_tests + 1)) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the tests did not finish",
             TEST_CYCLES * (n_tests + 1));
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- testbench/vlsu_shuffle_properties.sv
`timescale 1ns/1ps
`include "vlsu_shuffle_defs.svh"

module vlsu_shuffle_properties #(
  parameter int unsigned CNT_W = $clog2(`LANE_CREDITS + 1)
) (
  input logic                            clk_i,
  input logic                            rst_ni,
  input logic [`NR_LANES-1:0]            lane_valid_i,
  input logic [`NR_LANES-1:0]            lane_credit_i,
  input logic [`NR_LANES-1:0][CNT_W-1:0] credit_i,
  input logic                            commit_i,
  input logic                            info_valid_i,
  input logic [7:0]                      cmt_cnt_i,
  input logic [$clog2(`NR_VRF_SETS)-1:0] vaddr_set_i
);

  // Failed assertions so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // Beats each lane holds and has not freed yet
  logic [`NR_LANES-1:0][CNT_W-1:0] held_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= '0;
    end else begin
      for (int l = 0; l < `NR_LANES; l++) begin
        held_q[l] <= held_q[l] + CNT_W'(lane_valid_i[l]) - CNT_W'(lane_credit_i[l]);
      end
    end
  end

  for (genvar l = 0; l < `NR_LANES; l++) begin : g_lane
    // Beat only while the lane still has a free entry
    a_issue_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
      lane_valid_i[l] |-> (held_q[l] < CNT_W'(`LANE_CREDITS)))
      else begin
        $error("lane %0d issued a beat with no credit", l);
        fail_cnt++;
      end

    a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
      credit_i[l] <= CNT_W'(`LANE_CREDITS))
      else begin
        $error("lane %0d credit count above its entry count", l);
        fail_cnt++;
      end
  end

  // Request stays at the head until its last beat
  a_commit_info: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i && (cmt_cnt_i != '0) |=>
      info_valid_i && (cmt_cnt_i == $past(cmt_cnt_i) - 8'd1))
    else begin
      $error("info queue lost a request before its last beat");
      fail_cnt++;
    end

  // Last beat of the head request still inside the register file
  a_set_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    info_valid_i |-> (int'(vaddr_set_i) + int'(cmt_cnt_i) < `NR_VRF_SETS))
    else begin
      $error("register file set out of range");
      fail_cnt++;
    end

endmodule

//--- logic/vlsu_shuffle_top.sv
`timescale 1ns/1ps
`include "vlsu_shuffle_defs.svh"

module vlsu_shuffle_top #(
  parameter int unsigned INFO_DEPTH = 4
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Meta commands
  input  logic                                          meta_valid_i,
  output logic                                          meta_ready_o,
  input  vlsu_shuffle_pkg::meta_cmd_t                   meta_i,
  // Sequential beats
  input  logic                                          seq_valid_i,
  output logic                                          seq_ready_o,
  input  logic [`SEQ_NIBS-1:0][3:0]                     seq_data_i,
  input  logic [`SEQ_NIBS-1:0]                          seq_en_i,
  // Mask words
  input  logic                                          mask_valid_i,
  input  logic [`NR_LANES-1:0][`NIB_PER_LANE-1:0]       mask_bits_i,
  output logic                                          mask_ready_o,
  // Lanes
  output logic [`NR_LANES-1:0]                          lane_valid_o,
  output vlsu_shuffle_pkg::lane_word_t [`NR_LANES-1:0]  lane_word_o,
  input  logic [`NR_LANES-1:0]                          lane_credit_i
);
  import vlsu_shuffle_pkg::*;

  // Head request and commit pulse
  logic      info_valid;
  shf_info_t info;
  logic      commit;

  // Crossbar to shuffle buffer
  logic [`NR_LANES-1:0][`NIB_PER_LANE-1:0][3:0] xbar_data;
  logic [`NR_LANES-1:0][`NIB_PER_LANE-1:0]      xbar_nbe;

  shf_info_queue #(
    .DEPTH (INFO_DEPTH)
  ) i_shf_info_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_valid_i (meta_valid_i),
    .meta_ready_o (meta_ready_o),
    .meta_i       (meta_i),
    .info_valid_o (info_valid),
    .info_o       (info),
    .commit_i     (commit)
  );

  // Permutation follows the head request
  shf_nibble_xbar i_shf_nibble_xbar (
    .seq_data_i  (seq_data_i),
    .seq_en_i    (seq_en_i),
    .sew_i       (info.sew),
    .vm_i        (info.vm),
    .mask_bits_i (mask_bits_i),
    .lane_data_o (xbar_data),
    .lane_nbe_o  (xbar_nbe)
  );

  shf_shuffle_unit i_shf_shuffle_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .seq_valid_i   (seq_valid_i),
    .seq_ready_o   (seq_ready_o),
    .mask_valid_i  (mask_valid_i),
    .mask_ready_o  (mask_ready_o),
    .info_valid_i  (info_valid),
    .info_i        (info),
    .commit_o      (commit),
    .lane_data_i   (xbar_data),
    .lane_nbe_i    (xbar_nbe),
    .lane_valid_o  (lane_valid_o),
    .lane_word_o   (lane_word_o),
    .lane_credit_i (lane_credit_i)
  );

endmodule

//--- logic/shf_shuffle_unit.sv
`timescale 1ns/1ps
`include "vlsu_shuffle_defs.svh"

module shf_shuffle_unit (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Sequential beat handshake
  input  logic                                          seq_valid_i,
  output logic                                          seq_ready_o,
  // Mask handshake
  input  logic                                          mask_valid_i,
  output logic                                          mask_ready_o,
  // Head of the info queue
  input  logic                                          info_valid_i,
  input  vlsu_shuffle_pkg::shf_info_t                   info_i,
  output logic                                          commit_o,
  // Crossbar result
  input  logic [`NR_LANES-1:0][`NIB_PER_LANE-1:0][3:0]  lane_data_i,
  input  logic [`NR_LANES-1:0][`NIB_PER_LANE-1:0]       lane_nbe_i,
  // Lane side with credits
  output logic [`NR_LANES-1:0]                          lane_valid_o,
  output vlsu_shuffle_pkg::lane_word_t [`NR_LANES-1:0]  lane_word_o,
  input  logic [`NR_LANES-1:0]                          lane_credit_i
);
  import vlsu_shuffle_pkg::*;

  localparam int unsigned CNT_W = $clog2(`LANE_CREDITS + 1);

  // Shuffle buffer per lane
  logic       [`NR_LANES-1:0] buf_valid_q;
  lane_word_t [`NR_LANES-1:0] buf_word_q;

  // Free receive entries per lane
  logic [`NR_LANES-1:0][CNT_W-1:0] credit_q;

  logic buf_empty;

  // --------------------------------------------------------------------------
  // Commit control
  // --------------------------------------------------------------------------
  assign buf_empty = ~|buf_valid_q;

  // Whole beat moves at once, so every lane buffer must be free
  // Masked request also waits for its mask word
  assign seq_ready_o  = buf_empty && info_valid_i && (info_i.vm || mask_valid_i);
  assign commit_o     = seq_valid_i && seq_ready_o;
  // Mask consumed together with the beat
  assign mask_ready_o = commit_o && !info_i.vm;

  // --------------------------------------------------------------------------
  // Lane issue
  // --------------------------------------------------------------------------
  // Issue only with a free entry on the far side
  always_comb begin
    for (int l = 0; l < `NR_LANES; l++) begin
      lane_valid_o[l] = buf_valid_q[l] && (credit_q[l] != '0);
      lane_word_o[l]  = buf_word_q[l];
    end
  end

  // Valid bits
  // Commit happens only with all buffers empty, so no issue in that cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= '0;
    end else if (commit_o) begin
      buf_valid_q <= '1;
    end else begin
      // Clear as each lane issues
      buf_valid_q <= buf_valid_q & ~lane_valid_o;
    end
  end

  // Payload latched at commit with the head tags
  always_ff @(posedge clk_i) begin
    if (commit_o) begin
      for (int l = 0; l < `NR_LANES; l++) begin
        buf_word_q[l].data       <= lane_data_i[l];
        buf_word_q[l].nbe        <= lane_nbe_i[l];
        buf_word_q[l].req_id     <= info_i.req_id;
        buf_word_q[l].vaddr_set  <= info_i.vaddr_set;
        buf_word_q[l].vaddr_bank <= info_i.vaddr_bank;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Credit counters
  // --------------------------------------------------------------------------
  // Beat takes one, returned pulse gives one back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int l = 0; l < `NR_LANES; l++) begin
        credit_q[l] <= CNT_W'(`LANE_CREDITS);
      end
    end else begin
      for (int l = 0; l < `NR_LANES; l++) begin
        credit_q[l] <= credit_q[l] - CNT_W'(lane_valid_o[l]) + CNT_W'(lane_credit_i[l]);
      end
    end
  end

endmodule

//--- logic/shf_nibble_xbar.sv
`timescale 1ns/1ps
`include "vlsu_shuffle_defs.svh"

module shf_nibble_xbar (
  // Sequential beat in memory order
  input  logic [`SEQ_NIBS-1:0][3:0]                    seq_data_i,
  input  logic [`SEQ_NIBS-1:0]                         seq_en_i,
  // Head request attributes
  input  vlsu_shuffle_pkg::sew_t                       sew_i,
  input  logic                                         vm_i,
  input  logic [`NR_LANES-1:0][`NIB_PER_LANE-1:0]      mask_bits_i,
  // Lane order result
  output logic [`NR_LANES-1:0][`NIB_PER_LANE-1:0][3:0] lane_data_o,
  output logic [`NR_LANES-1:0][`NIB_PER_LANE-1:0]      lane_nbe_o
);
  import vlsu_shuffle_pkg::*;

  localparam int unsigned SEQ_IDX_W = $clog2(`SEQ_NIBS);

  // Sequential nibble that lands at (lane, off)
  // Element size is a power of two so divide and modulo become shifts
  function automatic logic [SEQ_IDX_W-1:0] seq_idx(int unsigned lane, int unsigned off,
                                                   sew_t sew);
    int unsigned sh;
    int unsigned k;
    int unsigned n;
    sh = int'(sew) + 1;
    // Element index within the lane
    k  = off >> sh;
    // Nibble within the element
    n  = off & ((1 << sh) - 1);
    return SEQ_IDX_W'(((k * `NR_LANES + lane) << sh) | n);
  endfunction

  for (genvar l = 0; l < `NR_LANES; l++) begin : g_lane
    for (genvar o = 0; o < `NIB_PER_LANE; o++) begin : g_nib
      logic [SEQ_IDX_W-1:0] idx;

      // Mux select per destination nibble
      assign idx = seq_idx(l, o, sew_i);

      assign lane_data_o[l][o] = seq_data_i[idx];
      // Mask only matters for masked requests
      assign lane_nbe_o[l][o]  = seq_en_i[idx] & (vm_i | mask_bits_i[l][o]);
    end
  end

endmodule

//--- logic/shf_info_queue.sv
`timescale 1ns/1ps
`include "vlsu_shuffle_defs.svh"

module shf_info_queue #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Meta command port
  input  logic                        meta_valid_i,
  output logic                        meta_ready_o,
  input  vlsu_shuffle_pkg::meta_cmd_t meta_i,
  // Head request toward the shuffle unit
  output logic                        info_valid_o,
  output vlsu_shuffle_pkg::shf_info_t info_o,
  input  logic                        commit_i
);
  import vlsu_shuffle_pkg::*;

  localparam int unsigned PTR_W   = $clog2(DEPTH);
  localparam int unsigned VADDR_W = $clog2(`NR_VRF_SETS) + `VADDR_BANK_BITS;

  // Storage, payload only
  shf_info_t mem_q [DEPTH];

  // Pointers carry a wrap flag in the MSB
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;

  logic empty;
  logic full;
  logic enq;
  logic deq;

  logic [15:0]        start_elem;
  logic [VADDR_W-1:0] start_addr;
  shf_info_t          enq_info;

  // --------------------------------------------------------------------------
  // Occupancy
  // --------------------------------------------------------------------------
  assign empty = (wr_ptr_q == rd_ptr_q);
  // Same slot but opposite lap
  assign full  = (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]) &&
                 (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]);

  assign meta_ready_o = !full;
  assign info_valid_o = !empty;
  assign info_o       = mem_q[rd_ptr_q[PTR_W-1:0]];

  assign enq = meta_valid_i && meta_ready_o;
  // Pop only after the last beat of the head request
  assign deq = commit_i && (info_o.cmt_cnt == '0);

  // --------------------------------------------------------------------------
  // Start address at enqueue
  // --------------------------------------------------------------------------
  // Elements per lane before vstart
  assign start_elem = meta_i.vstart >> $clog2(`NR_LANES);
  // Base set of vd plus the sets skipped by vstart
  assign start_addr = VADDR_W'(meta_i.vd) * VADDR_W'(`SETS_PER_VREG) +
                      VADDR_W'(start_elem >> (2'd3 - meta_i.sew));

  always_comb begin
    enq_info            = '0;
    enq_info.req_id     = meta_i.req_id;
    enq_info.sew        = meta_i.sew;
    enq_info.vm         = meta_i.vm;
    enq_info.cmt_cnt    = meta_i.cmt_cnt;
    // Bank in the low bits, set above
    enq_info.vaddr_set  = start_addr[VADDR_W-1:`VADDR_BANK_BITS];
    enq_info.vaddr_bank = start_addr[`VADDR_BANK_BITS-1:0];
  end

  // --------------------------------------------------------------------------
  // Pointers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (enq) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (deq) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Entry writes and head update
  // Enqueue slot never equals the head while the head is in use
  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_q[wr_ptr_q[PTR_W-1:0]] <= enq_info;
    end
    if (commit_i && !deq) begin
      // Next beat goes one set further
      mem_q[rd_ptr_q[PTR_W-1:0]].cmt_cnt   <= info_o.cmt_cnt - 1'b1;
      mem_q[rd_ptr_q[PTR_W-1:0]].vaddr_set <= info_o.vaddr_set + 1'b1;
    end
  end

endmodule

//--- logic/vlsu_shuffle_pkg.sv
`include "vlsu_shuffle_defs.svh"

package vlsu_shuffle_pkg;

  // Element width code
  // 0 -> 8b, 1 -> 16b, 2 -> 32b, 3 -> 64b
  typedef logic [1:0] sew_t;

  typedef logic [3:0] req_id_t;

  // Register file address parts
  typedef logic [$clog2(`NR_VRF_SETS)-1:0] vaddr_set_t;
  typedef logic [`VADDR_BANK_BITS-1:0]     vaddr_bank_t;

  // Load request as issued by the control side
  typedef struct packed {
    req_id_t     req_id;
    sew_t        sew;
    logic [4:0]  vd;
    logic [15:0] vstart;
    logic        vm;       // 1 means unmasked
    logic [7:0]  cmt_cnt;  // Beats minus one
  } meta_cmd_t;

  // Request entry kept in the info queue
  typedef struct packed {
    req_id_t     req_id;
    sew_t        sew;
    logic        vm;
    logic [7:0]  cmt_cnt;
    vaddr_set_t  vaddr_set;
    vaddr_bank_t vaddr_bank;
  } shf_info_t;

  // One word toward a lane
  typedef struct packed {
    logic [`NIB_PER_LANE*4-1:0] data;
    logic [`NIB_PER_LANE-1:0]   nbe;
    req_id_t                    req_id;
    vaddr_set_t                 vaddr_set;
    vaddr_bank_t                vaddr_bank;
  } lane_word_t;

endpackage

//--- include/vlsu_shuffle_defs.svh
`ifndef VLSU_SHUFFLE_DEFS_SVH
`define VLSU_SHUFFLE_DEFS_SVH

// Lane geometry
`define NR_LANES        4
`define NIB_PER_LANE    16
// Nibbles in one sequential beat
`define SEQ_NIBS        (`NR_LANES * `NIB_PER_LANE)

// Receive entries per lane
`define LANE_CREDITS    2

// Register file layout
`define SETS_PER_VREG   8
`define NR_VRF_SETS     256
`define VADDR_BANK_BITS 2

`endif
